//--- zynq_dram_defines.svh
`ifndef ZYNQ_DRAM_DEFINES_SVH
`define ZYNQ_DRAM_DEFINES_SVH

// processor and axi address width
`define ZD_ADDR_W       32

// host register port
`define ZD_CSR_W        32
`define ZD_CSR_ADDR_W   3

// memory profiler, one bit per region of processor dram
`define ZD_PROF_REGIONS 128
`define ZD_PROF_MSB     29
`define ZD_PROF_LSB     23

// processor-side dram base, removed by xor before the allocated base is added
`define ZD_DRAM_WINDOW  32'h8000_0000

// request queue entries
`define ZD_FIFO_DEPTH   4

// register map, profiler spans prof0 .. prof0+3 lsw first
`define ZD_CSR_CTRL     3'd0
`define ZD_CSR_INIT     3'd1
`define ZD_CSR_BASE     3'd2
`define ZD_CSR_PROF0    3'd3

`endif

//--- zynq_dram_pkg.sv
`include "zynq_dram_defines.svh"

package zynq_dram_pkg;

   // address on either side of the translation
   typedef logic [`ZD_ADDR_W-1:0]     addr_t;

   // host register port
   typedef logic [`ZD_CSR_W-1:0]      csr_data_t;
   typedef logic [`ZD_CSR_ADDR_W-1:0] csr_addr_t;

   // profiler vector and the index into it
   typedef logic [`ZD_PROF_REGIONS-1:0]          prof_t;
   typedef logic [`ZD_PROF_MSB-`ZD_PROF_LSB:0]   region_t;

   // axi address issuer
   typedef enum logic [1:0]
   {
      IDLE = 2'd0,
      AW   = 2'd1,
      AR   = 2'd2
   } issue_state_e;

endpackage

//--- dram_req_if.sv
// one translated memory request moving between pipeline stages
interface dram_req_if;

   logic                 valid;
   logic                 ready;
   // 1 for a write, 0 for a read
   logic                 write;
   zynq_dram_pkg::addr_t addr;

   // valid, write and addr hold steady until the cycle with valid and ready
   modport source
   (
      output valid,
      output write,
      output addr,
      input  ready
   );

   modport sink
   (
      input  valid,
      input  write,
      input  addr,
      output ready
   );

endinterface

//--- dram_csr_bank.sv
`include "zynq_dram_defines.svh"

module dram_csr_bank
  ( input  logic                      aclk
  , input  logic                      rst_i
  , input  logic                      csr_we_i
  , input  zynq_dram_pkg::csr_addr_t  csr_waddr_i
  , input  zynq_dram_pkg::csr_data_t  csr_wdata_i
  , input  zynq_dram_pkg::csr_addr_t  csr_raddr_i
  , output zynq_dram_pkg::csr_data_t  csr_rdata_o
  , input  zynq_dram_pkg::prof_t      mem_prof_i
  , output logic                      dram_init_o
  , output zynq_dram_pkg::addr_t      dram_base_o
  , output logic                      sys_reset_o
  );

   zynq_dram_pkg::csr_data_t ctrl_r;
   zynq_dram_pkg::csr_data_t init_r;
   zynq_dram_pkg::csr_data_t base_r;

   ////////////////////////////////////////////////////////////////////////////
   // host writes, profiler words are read only

   always_ff @(posedge aclk)
   begin
      if (rst_i)
      begin
         ctrl_r <= '0;
         init_r <= '0;
         base_r <= '0;
      end
      else if (csr_we_i)
      begin
         case (csr_waddr_i)
            `ZD_CSR_CTRL: ctrl_r <= csr_wdata_i;
            `ZD_CSR_INIT: init_r <= csr_wdata_i;
            `ZD_CSR_BASE: base_r <= csr_wdata_i;
            default: ;
         endcase
      end
   end

   // ctrl bit 0 is the soft reset, low true
   assign sys_reset_o = rst_i | ~ctrl_r[0];
   assign dram_init_o = init_r[0];
   assign dram_base_o = base_r;

   ////////////////////////////////////////////////////////////////////////////
   // readback

   always_comb
   begin
      case (csr_raddr_i)
         `ZD_CSR_CTRL:         csr_rdata_o = ctrl_r;
         `ZD_CSR_INIT:         csr_rdata_o = init_r;
         `ZD_CSR_BASE:         csr_rdata_o = base_r;
         `ZD_CSR_PROF0:        csr_rdata_o = mem_prof_i[0*`ZD_CSR_W +: `ZD_CSR_W];
         `ZD_CSR_PROF0 + 3'd1: csr_rdata_o = mem_prof_i[1*`ZD_CSR_W +: `ZD_CSR_W];
         `ZD_CSR_PROF0 + 3'd2: csr_rdata_o = mem_prof_i[2*`ZD_CSR_W +: `ZD_CSR_W];
         `ZD_CSR_PROF0 + 3'd3: csr_rdata_o = mem_prof_i[3*`ZD_CSR_W +: `ZD_CSR_W];
         // unmapped
         default:              csr_rdata_o = '0;
      endcase
   end

endmodule

//--- dram_addr_xlate.sv
`include "zynq_dram_defines.svh"

module dram_addr_xlate
  ( input  logic                  aclk
  , input  logic                  sys_reset_i
  , input  logic                  dram_init_i
  , input  zynq_dram_pkg::addr_t  dram_base_i
  , input  logic                  dma_v_i
  , input  logic                  dma_write_i
  , input  zynq_dram_pkg::addr_t  dma_addr_i
  , output logic                  dma_ready_o
  , output zynq_dram_pkg::prof_t  mem_prof_o
  , dram_req_if.source            out_q
  );

   logic                   take_req;
   zynq_dram_pkg::region_t region;
   zynq_dram_pkg::prof_t   prof_r;
   logic                   out_v_r;
   logic                   out_write_r;
   zynq_dram_pkg::addr_t   out_addr_r;

   // output stage is free when empty or handing its request on this cycle
   assign dma_ready_o = ~sys_reset_i & dram_init_i & (~out_v_r | out_q.ready);
   assign take_req    = dma_v_i & dma_ready_o;
   assign region      = dma_addr_i[`ZD_PROF_MSB:`ZD_PROF_LSB];

   always_ff @(posedge aclk)
   begin
      if (sys_reset_i)
         out_v_r <= 1'b0;
      else if (take_req)
         out_v_r <= 1'b1;
      else if (out_q.ready)
         out_v_r <= 1'b0;
   end

   // processor dram space to ps dram space
   always_ff @(posedge aclk)
   begin
      if (take_req)
      begin
         out_write_r <= dma_write_i;
         out_addr_r  <= (dma_addr_i ^ `ZD_DRAM_WINDOW) + dram_base_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // memory profiler, sticky until the next soft reset

   always_ff @(posedge aclk)
   begin
      if (sys_reset_i)
         prof_r <= '0;
      else if (take_req)
         prof_r[region] <= 1'b1;
   end

   assign mem_prof_o  = prof_r;

   assign out_q.valid = out_v_r;
   assign out_q.write = out_write_r;
   assign out_q.addr  = out_addr_r;

   // an offered request waits unchanged until the queue takes it
   assert property (@(posedge aclk) disable iff (sys_reset_i)
      out_q.valid && !out_q.ready
      |=> out_q.valid && $stable(out_q.addr) && $stable(out_q.write));

endmodule

//--- dram_req_fifo.sv
`include "zynq_dram_defines.svh"

module dram_req_fifo
  #(parameter int depth_p = `ZD_FIFO_DEPTH)
  ( input  logic        aclk
  , input  logic        sys_reset_i
  , dram_req_if.sink    in_q
  , dram_req_if.source  out_q
  );

   localparam int ptr_w_lp = $clog2(depth_p);
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   zynq_dram_pkg::addr_t addr_mem [depth_p];
   logic                 write_mem [depth_p];
   logic [ptr_w_lp-1:0]  wr_ptr_r;
   logic [ptr_w_lp-1:0]  rd_ptr_r;
   logic [cnt_w_lp-1:0]  count_r;
   logic                 push;
   logic                 pop;

   assign in_q.ready  = (count_r != cnt_w_lp'(depth_p));
   assign out_q.valid = (count_r != '0);
   assign push        = in_q.valid & in_q.ready;
   assign pop         = out_q.valid & out_q.ready;

   // head entry comes straight from storage
   assign out_q.addr  = addr_mem[rd_ptr_r];
   assign out_q.write = write_mem[rd_ptr_r];

   always_ff @(posedge aclk)
   begin
      if (push)
      begin
         addr_mem[wr_ptr_r]  <= in_q.addr;
         write_mem[wr_ptr_r] <= in_q.write;
      end
   end

   // pointers wrap on their own since depth is a power of two
   always_ff @(posedge aclk)
   begin
      if (sys_reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         if (push && !pop)
            count_r <= count_r + 1'b1;
         else if (pop && !push)
            count_r <= count_r - 1'b1;
      end
   end

   // a write never lands on an entry that is still unread
   assert property (@(posedge aclk) disable iff (sys_reset_i)
      push |-> (count_r == '0) || (wr_ptr_r != rd_ptr_r));

   // a read always takes an entry that was written
   assert property (@(posedge aclk) disable iff (sys_reset_i)
      pop |-> (count_r == cnt_w_lp'(depth_p)) || (wr_ptr_r != rd_ptr_r));

endmodule

//--- dram_axi_issue.sv
module dram_axi_issue
  ( input  logic                  aclk
  , input  logic                  sys_reset_i
  , dram_req_if.sink              in_q
  , output zynq_dram_pkg::addr_t  m_axi_awaddr_o
  , output zynq_dram_pkg::addr_t  m_axi_araddr_o
  , output logic                  m_axi_awvalid_o
  , output logic                  m_axi_arvalid_o
  , input  logic                  m_axi_awready_i
  , input  logic                  m_axi_arready_i
  );

   zynq_dram_pkg::issue_state_e state_r;
   zynq_dram_pkg::addr_t        addr_r;

   // a new request is taken only from idle
   assign in_q.ready      = (state_r == zynq_dram_pkg::IDLE);

   assign m_axi_awvalid_o = (state_r == zynq_dram_pkg::AW);
   assign m_axi_arvalid_o = (state_r == zynq_dram_pkg::AR);
   assign m_axi_awaddr_o  = addr_r;
   assign m_axi_araddr_o  = addr_r;

   always_ff @(posedge aclk)
   begin
      if (sys_reset_i)
         state_r <= zynq_dram_pkg::IDLE;
      else
      begin
         case (state_r)
            zynq_dram_pkg::IDLE:
            begin
               if (in_q.valid)
               begin
                  if (in_q.write)
                     state_r <= zynq_dram_pkg::AW;
                  else
                     state_r <= zynq_dram_pkg::AR;
               end
            end
            zynq_dram_pkg::AW:
            begin
               if (m_axi_awready_i)
                  state_r <= zynq_dram_pkg::IDLE;
            end
            zynq_dram_pkg::AR:
            begin
               if (m_axi_arready_i)
                  state_r <= zynq_dram_pkg::IDLE;
            end
            default: state_r <= zynq_dram_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge aclk)
   begin
      if (in_q.valid && in_q.ready)
         addr_r <= in_q.addr;
   end

   // the queue head waits unchanged while an earlier request is still on axi
   assert property (@(posedge aclk) disable iff (sys_reset_i)
      in_q.valid && !in_q.ready
      |=> in_q.valid && $stable(in_q.addr) && $stable(in_q.write));

   // valid and address hold until the slave takes them
   assert property (@(posedge aclk) disable iff (sys_reset_i)
      m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o && $stable(m_axi_awaddr_o));

   assert property (@(posedge aclk) disable iff (sys_reset_i)
      m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o));

endmodule

//--- zynq_dram_bridge.sv
module zynq_dram_bridge
  ( input  logic                      aclk
  , input  logic                      rst_i

  // host register port
  , input  logic                      csr_we_i
  , input  zynq_dram_pkg::csr_addr_t  csr_waddr_i
  , input  zynq_dram_pkg::csr_data_t  csr_wdata_i
  , input  zynq_dram_pkg::csr_addr_t  csr_raddr_i
  , output zynq_dram_pkg::csr_data_t  csr_rdata_o

  // processor memory requests
  , input  logic                      dma_v_i
  , input  logic                      dma_write_i
  , input  zynq_dram_pkg::addr_t      dma_addr_i
  , output logic                      dma_ready_o

  // axi master address channels
  , output zynq_dram_pkg::addr_t      m_axi_awaddr_o
  , output logic                      m_axi_awvalid_o
  , input  logic                      m_axi_awready_i
  , output zynq_dram_pkg::addr_t      m_axi_araddr_o
  , output logic                      m_axi_arvalid_o
  , input  logic                      m_axi_arready_i
  );

   logic                 dram_init;
   zynq_dram_pkg::addr_t dram_base;
   logic                 sys_reset;
   zynq_dram_pkg::prof_t mem_prof;

   dram_req_if xlate_q ();
   dram_req_if issue_q ();

   ////////////////////////////////////////////////////////////////////////////
   // control registers

   dram_csr_bank csr
     ( .aclk        (aclk)
     , .rst_i       (rst_i)
     , .csr_we_i    (csr_we_i)
     , .csr_waddr_i (csr_waddr_i)
     , .csr_wdata_i (csr_wdata_i)
     , .csr_raddr_i (csr_raddr_i)
     , .csr_rdata_o (csr_rdata_o)
     , .mem_prof_i  (mem_prof)
     , .dram_init_o (dram_init)
     , .dram_base_o (dram_base)
     , .sys_reset_o (sys_reset)
     );

   ////////////////////////////////////////////////////////////////////////////
   // request path: translate, queue, issue

   dram_addr_xlate xlate
     ( .aclk        (aclk)
     , .sys_reset_i (sys_reset)
     , .dram_init_i (dram_init)
     , .dram_base_i (dram_base)
     , .dma_v_i     (dma_v_i)
     , .dma_write_i (dma_write_i)
     , .dma_addr_i  (dma_addr_i)
     , .dma_ready_o (dma_ready_o)
     , .mem_prof_o  (mem_prof)
     , .out_q       (xlate_q)
     );

   dram_req_fifo fifo
     ( .aclk        (aclk)
     , .sys_reset_i (sys_reset)
     , .in_q        (xlate_q)
     , .out_q       (issue_q)
     );

   dram_axi_issue issue
     ( .aclk            (aclk)
     , .sys_reset_i     (sys_reset)
     , .in_q            (issue_q)
     , .m_axi_awaddr_o  (m_axi_awaddr_o)
     , .m_axi_araddr_o  (m_axi_araddr_o)
     , .m_axi_awvalid_o (m_axi_awvalid_o)
     , .m_axi_arvalid_o (m_axi_arvalid_o)
     , .m_axi_awready_i (m_axi_awready_i)
     , .m_axi_arready_i (m_axi_arready_i)
     );

endmodule

//--- tb_clkgen.sv
// free running testbench clock
module tb_clkgen
  #(parameter int period_p = 8)
  ( output logic clk_o
  );

   initial
   begin
      clk_o = 1'b0;
      forever
         #(period_p / 2) clk_o = ~clk_o;
   end

endmodule

//--- tb_zynq_dram_bridge.sv
`include "zynq_dram_defines.svh"

module tb_zynq_dram_bridge;

   localparam int timeout_cycles = 500;

   logic                      aclk;
   logic                      rst_i;
   logic                      csr_we_i;
   zynq_dram_pkg::csr_addr_t  csr_waddr_i;
   zynq_dram_pkg::csr_data_t  csr_wdata_i;
   zynq_dram_pkg::csr_addr_t  csr_raddr_i;
   zynq_dram_pkg::csr_data_t  csr_rdata_o;
   logic                      dma_v_i;
   logic                      dma_write_i;
   zynq_dram_pkg::addr_t      dma_addr_i;
   logic                      dma_ready_o;
   zynq_dram_pkg::addr_t      m_axi_awaddr_o;
   logic                      m_axi_awvalid_o;
   logic                      m_axi_awready_i;
   zynq_dram_pkg::addr_t      m_axi_araddr_o;
   logic                      m_axi_arvalid_o;
   logic                      m_axi_arready_i;

   // expected axi requests in order, top bit is the write flag
   logic [`ZD_ADDR_W:0] exp_q [$];
   logic [31:0]         lfsr;
   logic                aw_bit;
   logic                ar_bit;
   logic                axi_block;
   logic                abort;
   int                  error_count = 0;
   int                  issue_count = 0;
   int                  req_count = 0;

   tb_clkgen #(.period_p(8)) i_clk (.clk_o(aclk));

   zynq_dram_bridge i_dut
     ( .aclk            (aclk)
     , .rst_i           (rst_i)
     , .csr_we_i        (csr_we_i)
     , .csr_waddr_i     (csr_waddr_i)
     , .csr_wdata_i     (csr_wdata_i)
     , .csr_raddr_i     (csr_raddr_i)
     , .csr_rdata_o     (csr_rdata_o)
     , .dma_v_i         (dma_v_i)
     , .dma_write_i     (dma_write_i)
     , .dma_addr_i      (dma_addr_i)
     , .dma_ready_o     (dma_ready_o)
     , .m_axi_awaddr_o  (m_axi_awaddr_o)
     , .m_axi_awvalid_o (m_axi_awvalid_o)
     , .m_axi_awready_i (m_axi_awready_i)
     , .m_axi_araddr_o  (m_axi_araddr_o)
     , .m_axi_arvalid_o (m_axi_arvalid_o)
     , .m_axi_arready_i (m_axi_arready_i)
     );

   ////////////////////////////////////////////////////////////////////////////
   // random axi ready and the check of issued requests

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h8020_0003;
      return n;
   endfunction

   task automatic next_ready_bit(output logic b);
      lfsr = lfsr_step(lfsr);
      b    = lfsr[0];
   endtask

   task automatic check_issue(input logic is_write, input zynq_dram_pkg::addr_t addr);
      logic [`ZD_ADDR_W:0] exp;
      issue_count++;
      assert (exp_q.size() != 0)
      else
      begin
         error_count++;
         $display("request to %h was issued while none was outstanding", addr);
      end
      if (exp_q.size() != 0)
      begin
         exp = exp_q.pop_front();
         assert (is_write == exp[`ZD_ADDR_W])
         else
         begin
            error_count++;
            $display("[ERROR] m_axi_awvalid_o got %h expected %h", is_write, exp[`ZD_ADDR_W]);
         end
         assert (addr == exp[`ZD_ADDR_W-1:0])
         else
         begin
            error_count++;
            $display("[ERROR] m_axi_%saddr_o got %h expected %h", is_write ? "aw" : "ar",
                     addr, exp[`ZD_ADDR_W-1:0]);
         end
      end
   endtask

   // valid and address only move on the rising edge, so they are sampled here
   always @(negedge aclk)
   begin
      next_ready_bit(aw_bit);
      next_ready_bit(ar_bit);
      m_axi_awready_i = aw_bit & ~axi_block;
      m_axi_arready_i = ar_bit & ~axi_block;
      #1;
      if (m_axi_awvalid_o && m_axi_awready_i)
         check_issue(1'b1, m_axi_awaddr_o);
      if (m_axi_arvalid_o && m_axi_arready_i)
         check_issue(1'b0, m_axi_araddr_o);
   end

   ////////////////////////////////////////////////////////////////////////////
   // command tasks

   task automatic write_reg(input zynq_dram_pkg::csr_addr_t addr,
                            input zynq_dram_pkg::csr_data_t data);
      @(negedge aclk);
      csr_we_i    = 1'b1;
      csr_waddr_i = addr;
      csr_wdata_i = data;
      @(negedge aclk);
      csr_we_i    = 1'b0;
   endtask

   task automatic read_reg(input zynq_dram_pkg::csr_addr_t addr,
                           input zynq_dram_pkg::csr_data_t exp);
      @(negedge aclk);
      csr_raddr_i = addr;
      #1;
      assert (csr_rdata_o == exp)
      else
      begin
         error_count++;
         $display("[ERROR] csr_rdata_o at %h got %h expected %h", addr, csr_rdata_o, exp);
      end
   endtask

   task automatic check_ready(input logic exp);
      @(negedge aclk);
      #1;
      assert (dma_ready_o == exp)
      else
      begin
         error_count++;
         $display("[ERROR] dma_ready_o got %h expected %h", dma_ready_o, exp);
      end
   endtask

   task automatic send_req(input logic is_write, input zynq_dram_pkg::addr_t addr,
                           input zynq_dram_pkg::addr_t exp);
      int cycles;
      cycles = 0;
      req_count++;
      exp_q.push_back({is_write, exp});
      @(negedge aclk);
      dma_v_i     = 1'b1;
      dma_write_i = is_write;
      dma_addr_i  = addr;
      #1;
      while (!dma_ready_o && cycles < timeout_cycles)
      begin
         @(negedge aclk);
         #1;
         cycles++;
      end
      assert (dma_ready_o)
      else
      begin
         error_count++;
         abort = 1'b1;
         $display("request to %h was never accepted", addr);
      end
      @(posedge aclk);
      @(negedge aclk);
      dma_v_i = 1'b0;
   endtask

   task automatic drain();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0 && cycles < timeout_cycles)
      begin
         @(negedge aclk);
         cycles++;
      end
      assert (exp_q.size() == 0)
      else
      begin
         error_count++;
         abort = 1'b1;
         $display("%0d requests never reached the axi port", exp_q.size());
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence, one command per data file line

   initial
   begin
      int          fd;
      int          n;
      int          fields;
      string       line;
      byte         cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      rst_i           = 1'b1;
      csr_we_i        = 1'b0;
      csr_waddr_i     = '0;
      csr_wdata_i     = '0;
      csr_raddr_i     = '0;
      dma_v_i         = 1'b0;
      dma_write_i     = 1'b0;
      dma_addr_i      = '0;
      m_axi_awready_i = 1'b0;
      m_axi_arready_i = 1'b0;
      lfsr            = 32'hdccec6ae;
      axi_block       = 1'b0;
      abort           = 1'b0;
      repeat (10) @(posedge aclk);
      @(negedge aclk);
      rst_i = 1'b0;
      fd = $fopen("zynq_dram_testdata.txt", "r");
      assert (fd != 0)
      else
      begin
         error_count++;
         $display("could not open zynq_dram_testdata.txt");
      end
      while (fd != 0 && !abort && !$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.getc(0) != "#")
         begin
            cmd    = line.getc(0);
            a      = '0;
            b      = '0;
            c      = '0;
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
            case (cmd)
               "W": write_reg(a[2:0], b);
               "R": read_reg(a[2:0], b);
               "N": check_ready(a[0]);
               "Q": send_req(a[0], b, c);
               // nonblocking so the ready driver sees a clean edge
               "B": axi_block <= a[0];
               "D": drain();
               default:
               begin
                  error_count++;
                  $display("unknown command %c with %0d fields in data file", cmd, fields);
               end
            endcase
         end
      end
      if (fd != 0)
         $fclose(fd);
      assert (abort || issue_count == req_count)
      else
      begin
         error_count++;
         $display("%0d requests sent but %0d issued", req_count, issue_count);
      end
      $display("errors %0d, requests %0d, issued %0d", error_count, req_count, issue_count);
      if (error_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- zynq_dram_testdata.txt
# cmd a b c in hex: W reg data, R reg expected, N expected dma_ready, B block axi ready
# Q write proc_addr expected_axi_addr, D wait until all requests are issued
R 0 00000000
R 1 00000000
R 2 00000000
N 0
W 0 00000001
N 0
W 2 20000000
W 1 00000001
N 1
R 0 00000001
R 1 00000001
R 2 20000000
W 7 deadbeef
R 7 00000000
B 1
Q 1 80000000 20000000
Q 0 80800040 20800040
Q 1 81001000 21001000
Q 0 90000000 30000000
Q 1 bf800000 5f800000
Q 0 8a000004 2a000004
N 0
B 0
D
Q 1 00000010 a0000010
Q 0 fffffff0 9ffffff0
D
R 3 00100007
R 4 00000001
R 5 00000000
R 6 80000000
W 0 00000000
N 0
R 3 00000000
R 6 00000000
W 0 00000001
Q 1 80000100 20000100
Q 0 80800000 20800000
Q 1 81800008 21800008
Q 0 00000000 a0000000
D
R 3 0000000b
R 4 00000000

//--- filelist.f
+incdir+.
zynq_dram_pkg.sv
dram_req_if.sv
dram_csr_bank.sv
dram_addr_xlate.sv
dram_req_fifo.sv
dram_axi_issue.sv
zynq_dram_bridge.sv
tb_clkgen.sv
tb_zynq_dram_bridge.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_zynq_dram_bridge
FILELIST   := filelist.f
VFLAGS     := --binary --assert
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
